//--- tmpDig_stim.txt
# columns: test name, comparator pulses, pulse spacing in cycles, expected total
# the total is tmpCount1 + tmpCount2 at window close, both clear after each sleep
burstA 5 4 5
burstB 7 3 12
idleA 0 4 0
single 1 5 1
wide 20 6 21
idleB 0 3 0
fast 40 3 40
finish 9 8 49

//--- tmpDig.f
+incdir+.
tmpDigPkg.sv
inputSync.sv
phaseSequencer.sv
chopSequencer.sv
ccoCounter.sv
tmpDig.sv
tmpDig_tb.sv

//--- Bender.yml
package:
  name: tmpDig

export_include_dirs:
  - .

sources:
  - tmpDigPkg.sv
  - inputSync.sv
  - phaseSequencer.sv
  - chopSequencer.sv
  - ccoCounter.sv
  - tmpDig.sv
  - target: simulation
    files:
      - tmpDig_tb.sv

//--- tmpDig_tb.sv
`timescale 1ns/1ps
`include "tmpDig_settings.svh"

module tmpDig_tb;

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DELAY = 2;
    localparam int RESET_CYCLES = 4;
    // toggling stops this long after a window so PTAT exits on a steady level
    localparam int TOGGLE_SPAN = 40;
    localparam int TOGGLE_GAP = 8;
    localparam int BG_BOUND = `TMPDIG_BG_ROUNDS * (2 * `TMPDIG_BIGDIODE_TIMEOUT
        + 2 * `TMPDIG_DIODE_CYCLES + 2 * `TMPDIG_CHARGE_CYCLES + `TMPDIG_BG_OUTPUT_CYCLES + 7);
    localparam int PTAT_BOUND = (`TMPDIG_PTAT_MIN_ROUNDS + 1)
        * (`TMPDIG_BIGDIODE_TIMEOUT + `TMPDIG_DIODE_CYCLES + 2);
    localparam int TEST_BOUND = BG_BOUND + PTAT_BOUND + `TMPDIG_SAMPLE_WINDOW
        + `TMPDIG_SLEEP_CYCLES;

    logic                   clk;
    logic                   reset;
    logic                   cmp;
    tmpDigPkg::biasPulse_t  bias;
    tmpDigPkg::switchCtrl_t switches;
    tmpDigPkg::ccoCaps_t    caps;
    logic                   cmpP1;
    logic                   cmpP2;
    logic                   pwrUp;
    logic                   preChrg;
    tmpDigPkg::ccoCount_t   tmpCount1;
    tmpDigPkg::ccoCount_t   tmpCount2;

    string testName[$];
    int    testPulses[$];
    int    testSpacing[$];
    int    testTotal[$];
    string currentTest;
    int    errorCount;
    int    testErrors;
    int    testsFailed;
    int    sinceClose;
    int    modelCount[2];
    int    edgeTotal;
    logic  holdLevel;
    logic  windowOpen;
    logic  started;

    tmpDig u_tmpDig (
        .clk       (clk),
        .reset     (reset),
        .cmp       (cmp),
        .bias      (bias),
        .switches  (switches),
        .caps      (caps),
        .cmpP1     (cmpP1),
        .cmpP2     (cmpP2),
        .pwrUp     (pwrUp),
        .preChrg   (preChrg),
        .tmpCount1 (tmpCount1),
        .tmpCount2 (tmpCount2)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic checkCount(input string what, input tmpDigPkg::ccoCount_t expected,
                              input tmpDigPkg::ccoCount_t actual);
        if (actual !== expected) begin
            $display("error %s: %s expected %0d actual %0d", currentTest, what, expected, actual);
            errorCount++;
            testErrors++;
        end
    endtask

    task automatic checkSwitches(input string what, input tmpDigPkg::switchCtrl_t expected,
                                 input tmpDigPkg::switchCtrl_t actual);
        if (actual !== expected) begin
            $display("error %s: %s expected %b actual %b", currentTest, what, expected, actual);
            errorCount++;
            testErrors++;
        end
    endtask

    task automatic checkCaps(input string what, input tmpDigPkg::ccoCaps_t expected,
                             input tmpDigPkg::ccoCaps_t actual);
        if (actual !== expected) begin
            $display("error %s: %s expected %b actual %b", currentTest, what, expected, actual);
            errorCount++;
            testErrors++;
        end
    endtask

    task automatic checkBias(input string what, input tmpDigPkg::biasPulse_t expected,
                             input tmpDigPkg::biasPulse_t actual);
        if (actual !== expected) begin
            $display("error %s: %s expected %b actual %b", currentTest, what, expected, actual);
            errorCount++;
            testErrors++;
        end
    endtask

    task automatic checkBit(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("error %s: %s expected %b actual %b", currentTest, what, expected, actual);
            errorCount++;
            testErrors++;
        end
    endtask

    task automatic checkCycles(input string what, input int expected, input int actual);
        if (actual != expected) begin
            $display("error %s: %s expected %0d actual %0d", currentTest, what, expected, actual);
            errorCount++;
            testErrors++;
        end
    endtask

    // caps swap on each counted edge, 10 after an odd number of edges
    function automatic tmpDigPkg::ccoCaps_t capsAfter(input int edges);
        tmpDigPkg::ccoCaps_t expected;
        expected = '0;
        if (edges > 0) begin
            expected.ccoCap1 = (edges % 2 == 1);
            expected.ccoCap2 = (edges % 2 == 0);
        end
        return expected;
    endfunction

    // sample and drive just after the rising edge
    task automatic nextCycle();
        @(posedge clk);
        #(DRIVE_DELAY);
        checkBit("cmpP2", ~cmpP1, cmpP2);
        // bias pulses belong to the bandgap and PTAT phases only
        if (switches.bg2Cmp !== 1'b1) begin
            checkBias("bias outside chopping", '0, bias);
        end
    endtask

    task automatic driveBackground();
        if (sinceClose >= TOGGLE_SPAN) begin
            cmp = holdLevel;
        end else if (sinceClose % TOGGLE_GAP == TOGGLE_GAP - 1) begin
            cmp = ~cmp;
        end
        sinceClose++;
    endtask

    task automatic waitWindow();
        nextCycle();
        while (switches.cap2Cmp !== 1'b1) begin
            checkBit("pwrUp outside window", 1'b1, pwrUp);
            driveBackground();
            nextCycle();
        end
        windowOpen = 1'b1;
    endtask

    task automatic finishTest();
        if (testErrors == 0) begin
            $display("test %s passed", currentTest);
        end else begin
            $display("test %s failed with %0d errors", currentTest, testErrors);
            testsFailed++;
        end
    endtask

    task automatic loadTests();
        int    fd;
        int    code;
        int    pulses;
        int    spacing;
        int    total;
        string line;
        string name;
        fd = $fopen("tmpDig_stim.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0) begin
                    code = $sscanf(line, "%s %d %d %d", name, pulses, spacing, total);
                    if (code == 4) begin
                        testName.push_back(name);
                        testPulses.push_back(pulses);
                        testSpacing.push_back(spacing);
                        testTotal.push_back(total);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic checkResetAndPrecharge();
        int highCycles;
        int waitCycles;
        currentTest = "precharge";
        testErrors = 0;
        repeat (RESET_CYCLES) begin
            nextCycle();
            checkSwitches("switches in reset", '0, switches);
            checkBit("pwrUp in reset", 1'b0, pwrUp);
            checkBit("preChrg in reset", 1'b0, preChrg);
            checkBit("cmpP1 in reset", 1'b0, cmpP1);
            checkCaps("caps in reset", '0, caps);
            checkCount("tmpCount1 in reset", '0, tmpCount1);
            checkCount("tmpCount2 in reset", '0, tmpCount2);
        end
        reset = 1'b0;
        waitCycles = 0;
        while (preChrg !== 1'b1 && waitCycles < 3) begin
            driveBackground();
            nextCycle();
            waitCycles++;
        end
        if (preChrg !== 1'b1) begin
            $display("%s: preChrg did not rise within 3 cycles of reset release", currentTest);
            errorCount++;
            testErrors++;
        end else begin
            highCycles = 0;
            while (preChrg === 1'b1) begin
                highCycles++;
                driveBackground();
                nextCycle();
            end
            checkCycles("precharge length", `TMPDIG_PRECHARGE_CYCLES, highCycles);
        end
        finishTest();
    endtask

    task automatic runTest(input int idx);
        int                   pol;
        int                   lowCycles;
        tmpDigPkg::ccoCount_t total;
        currentTest = testName[idx];
        testErrors = 0;
        if (!windowOpen) begin
            waitWindow();
        end
        windowOpen = 1'b0;
        // PTAT exit level decides which counter this window feeds
        pol = holdLevel;
        holdLevel = ~holdLevel;
        cmp = 1'b0;
        repeat (2) nextCycle();
        for (int i = 0; i < testPulses[idx]; i++) begin
            cmp = 1'b1;
            nextCycle();
            cmp = 1'b0;
            repeat (testSpacing[idx] - 1) nextCycle();
        end
        while (switches.cap2Cmp === 1'b1) begin
            nextCycle();
        end
        sinceClose = 0;
        modelCount[pol] += testPulses[idx];
        edgeTotal += testPulses[idx];
        checkCaps("caps at window end", capsAfter(edgeTotal), caps);
        if (testPulses[idx] > 0) begin
            total = tmpCount1 + tmpCount2;
            checkCount("count total", tmpDigPkg::ccoCount_t'(testTotal[idx]), total);
        end
        if (modelCount[0] > 0 && modelCount[1] > 0) begin
            checkBit("pwrUp at window end", 1'b0, pwrUp);
            lowCycles = 0;
            while (pwrUp !== 1'b1) begin
                lowCycles++;
                driveBackground();
                nextCycle();
            end
            checkCycles("sleep length", `TMPDIG_SLEEP_CYCLES, lowCycles);
            driveBackground();
            nextCycle();
            checkCount("count1 after wake", '0, tmpCount1);
            checkCount("count2 after wake", '0, tmpCount2);
            modelCount[0] = 0;
            modelCount[1] = 0;
        end else begin
            checkBit("pwrUp at window end", 1'b1, pwrUp);
            waitWindow();
        end
        finishTest();
    endtask

    initial begin
        int limit;
        wait (started === 1'b1);
        limit = 2 * testName.size() * TEST_BOUND + RESET_CYCLES + `TMPDIG_PRECHARGE_CYCLES;
        repeat (limit) @(posedge clk);
        $display("watchdog: run did not finish within %0d clock cycles", limit);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        cmp = 1'b0;
        errorCount = 0;
        testErrors = 0;
        testsFailed = 0;
        sinceClose = 0;
        modelCount[0] = 0;
        modelCount[1] = 0;
        edgeTotal = 0;
        holdLevel = 1'b1;
        windowOpen = 1'b0;
        started = 1'b0;
        loadTests();
        if (testName.size() == 0) begin
            $display("no tests could be read from tmpDig_stim.txt");
            $display("SIMULATION FAILED");
            $finish;
        end else begin
            started = 1'b1;
            checkResetAndPrecharge();
            foreach (testName[i]) begin
                runTest(i);
            end
            $display("%0d tests run, %0d failed, %0d errors", testName.size() + 1,
                     testsFailed, errorCount);
            if (errorCount == 0) begin
                $display("SIMULATION PASSED");
            end else begin
                $display("SIMULATION FAILED");
            end
            $finish;
        end
    end

endmodule

//--- tmpDig.sv
`timescale 1ns/1ps

module tmpDig (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cmp,
    output tmpDigPkg::biasPulse_t  bias,
    output tmpDigPkg::switchCtrl_t switches,
    output tmpDigPkg::ccoCaps_t    caps,
    output logic                   cmpP1,
    output logic                   cmpP2,
    output logic                   pwrUp,
    output logic                   preChrg,
    output tmpDigPkg::ccoCount_t   tmpCount1,
    output tmpDigPkg::ccoCount_t   tmpCount2
);

    logic              rstSync;
    logic              cmpSync;
    tmpDigPkg::phase_t phase;
    logic              phaseStart;
    logic              roundDone;
    logic              polarity;
    logic              countClear;

    inputSync u_inputSync (
        .clk     (clk),
        .reset   (reset),
        .cmp     (cmp),
        .rstSync (rstSync),
        .cmpSync (cmpSync)
    );

    phaseSequencer u_phaseSequencer (
        .clk        (clk),
        .rstSync    (rstSync),
        .cmpSync    (cmpSync),
        .roundDone  (roundDone),
        .count1     (tmpCount1),
        .count2     (tmpCount2),
        .phase      (phase),
        .phaseStart (phaseStart),
        .switches   (switches),
        .pwrUp      (pwrUp),
        .preChrg    (preChrg),
        .polarity   (polarity),
        .countClear (countClear)
    );

    chopSequencer u_chopSequencer (
        .clk        (clk),
        .rstSync    (rstSync),
        .cmpSync    (cmpSync),
        .phase      (phase),
        .phaseStart (phaseStart),
        .bias       (bias),
        .chopPol    (cmpP1),
        .roundDone  (roundDone)
    );

    ccoCounter u_ccoCounter (
        .clk        (clk),
        .rstSync    (rstSync),
        .cmpSync    (cmpSync),
        .capRst     (switches.capRst),
        .polarity   (polarity),
        .countClear (countClear),
        .count1     (tmpCount1),
        .count2     (tmpCount2),
        .caps       (caps)
    );

    // second comparator chopping phase
    assign cmpP2 = ~cmpP1;

endmodule

//--- ccoCounter.sv
`timescale 1ns/1ps

module ccoCounter (
    input  logic                 clk,
    input  logic                 rstSync,
    input  logic                 cmpSync,
    input  logic                 capRst,
    input  logic                 polarity,
    input  logic                 countClear,
    output tmpDigPkg::ccoCount_t count1,
    output tmpDigPkg::ccoCount_t count2,
    output tmpDigPkg::ccoCaps_t  caps
);

    logic cmpLast;
    logic countEdge;

    // rising comparator edge while the caps are released
    assign countEdge = cmpSync && !cmpLast && !capRst;

    always_ff @(posedge clk or posedge rstSync) begin
        if (rstSync) begin
            cmpLast <= 1'b0;
            count1  <= '0;
            count2  <= '0;
            caps    <= '0;
        end else begin
            cmpLast <= cmpSync;
            if (countClear) begin
                count1 <= '0;
                count2 <= '0;
            end else if (countEdge) begin
                if (polarity) begin
                    count1 <= count1 + 1'b1;
                end else begin
                    count2 <= count2 + 1'b1;
                end
            end
            // caps alternate 10/01 from the first counted edge on
            if (countEdge) begin
                caps.ccoCap1 <= ~caps.ccoCap1;
                caps.ccoCap2 <= caps.ccoCap1;
            end
        end
    end

endmodule

//--- chopSequencer.sv
`timescale 1ns/1ps
`include "tmpDig_settings.svh"

module chopSequencer (
    input  logic                  clk,
    input  logic                  rstSync,
    input  logic                  cmpSync,
    input  tmpDigPkg::phase_t     phase,
    input  logic                  phaseStart,
    output tmpDigPkg::biasPulse_t bias,
    output logic                  chopPol,
    output logic                  roundDone
);

    tmpDigPkg::chopState_t state;
    tmpDigPkg::chopState_t afterBlank;
    tmpDigPkg::stepCount_t stepCount;
    logic                  refCmp;
    logic                  hDone;
    logic                  active;
    logic                  cmpHeld;
    logic                  inPtat;

    assign inPtat  = (phase == tmpDigPkg::PTAT);
    assign active  = inPtat || (phase == tmpDigPkg::BANDGAP);
    assign cmpHeld = (cmpSync == refCmp);

    // pulse decode, PI1 and PII1 open one blank cycle early
    always_comb begin
        bias = '0;
        if (active) begin
            case (state)
                tmpDigPkg::DIODE: begin
                    bias.PII1 = 1'b1;
                    bias.PII2 = 1'b1;
                end
                tmpDigPkg::BIGDIODE: begin
                    bias.PI1  = 1'b1;
                    bias.PI2  = 1'b1;
                    bias.srcN = cmpHeld && cmpSync;
                    bias.snk  = cmpHeld && !cmpSync;
                end
                tmpDigPkg::HCHARGE: begin
                    bias.PA = 1'b1;
                    bias.PB = 1'b1;
                end
                tmpDigPkg::LCHARGE: begin
                    bias.PA = 1'b1;
                    bias.PC = 1'b1;
                end
                tmpDigPkg::OUTPUT: begin
                    bias.PB = 1'b1;
                    bias.PC = 1'b1;
                    bias.PD = 1'b1;
                end
                tmpDigPkg::BLANKDIODE: begin
                    bias.PII1 = (afterBlank == tmpDigPkg::DIODE);
                end
                default: begin
                    bias.PI1 = (afterBlank == tmpDigPkg::BIGDIODE);
                end
            endcase
        end
    end

    always_ff @(posedge clk or posedge rstSync) begin
        if (rstSync) begin
            state      <= tmpDigPkg::BLANKBIGDIODE;
            afterBlank <= tmpDigPkg::BIGDIODE;
            stepCount  <= '0;
            refCmp     <= 1'b0;
            hDone      <= 1'b0;
            chopPol    <= 1'b0;
            roundDone  <= 1'b0;
        end else begin
            roundDone <= 1'b0;
            if (phaseStart) begin
                stepCount <= '0;
                hDone     <= 1'b0;
                // PTAT opens on a diode, bandgap on a big diode
                if (inPtat) begin
                    state      <= tmpDigPkg::BLANKDIODE;
                    afterBlank <= tmpDigPkg::DIODE;
                end else begin
                    state      <= tmpDigPkg::BLANKBIGDIODE;
                    afterBlank <= tmpDigPkg::BIGDIODE;
                end
            end else if (active) begin
                stepCount <= stepCount + 1'b1;
                case (state)
                    tmpDigPkg::DIODE: begin
                        if (stepCount == tmpDigPkg::stepCount_t'(`TMPDIG_DIODE_CYCLES - 1)) begin
                            stepCount <= '0;
                            chopPol   <= ~chopPol;
                            if (inPtat) begin
                                roundDone  <= 1'b1;
                                state      <= tmpDigPkg::BLANKBIGDIODE;
                                afterBlank <= tmpDigPkg::BIGDIODE;
                            end else begin
                                state      <= tmpDigPkg::BLANKDIODE;
                                afterBlank <= hDone ? tmpDigPkg::LCHARGE : tmpDigPkg::HCHARGE;
                            end
                        end
                    end
                    // hold until the comparator flips or the timeout hits
                    tmpDigPkg::BIGDIODE: begin
                        if (!cmpHeld ||
                            stepCount == tmpDigPkg::stepCount_t'(`TMPDIG_BIGDIODE_TIMEOUT - 1)) begin
                            stepCount  <= '0;
                            state      <= tmpDigPkg::BLANKDIODE;
                            afterBlank <= tmpDigPkg::DIODE;
                        end
                    end
                    tmpDigPkg::HCHARGE: begin
                        if (stepCount == tmpDigPkg::stepCount_t'(`TMPDIG_CHARGE_CYCLES - 1)) begin
                            stepCount  <= '0;
                            hDone      <= 1'b1;
                            state      <= tmpDigPkg::BLANKBIGDIODE;
                            afterBlank <= tmpDigPkg::BIGDIODE;
                        end
                    end
                    tmpDigPkg::LCHARGE: begin
                        if (stepCount == tmpDigPkg::stepCount_t'(`TMPDIG_CHARGE_CYCLES - 1)) begin
                            stepCount  <= '0;
                            hDone      <= 1'b0;
                            state      <= tmpDigPkg::BLANKDIODE;
                            afterBlank <= tmpDigPkg::OUTPUT;
                        end
                    end
                    tmpDigPkg::OUTPUT: begin
                        if (stepCount == tmpDigPkg::stepCount_t'(`TMPDIG_BG_OUTPUT_CYCLES - 1)) begin
                            stepCount  <= '0;
                            roundDone  <= 1'b1;
                            state      <= tmpDigPkg::BLANKBIGDIODE;
                            afterBlank <= tmpDigPkg::BIGDIODE;
                        end
                    end
                    // single blank cycle, latch the comparator for the big diode
                    default: begin
                        stepCount <= '0;
                        refCmp    <= cmpSync;
                        state     <= afterBlank;
                    end
                endcase
            end
        end
    end

endmodule

//--- phaseSequencer.sv
`timescale 1ns/1ps
`include "tmpDig_settings.svh"

module phaseSequencer (
    input  logic                   clk,
    input  logic                   rstSync,
    input  logic                   cmpSync,
    input  logic                   roundDone,
    input  tmpDigPkg::ccoCount_t   count1,
    input  tmpDigPkg::ccoCount_t   count2,
    output tmpDigPkg::phase_t      phase,
    output logic                   phaseStart,
    output tmpDigPkg::switchCtrl_t switches,
    output logic                   pwrUp,
    output logic                   preChrg,
    output logic                   polarity,
    output logic                   countClear
);

    tmpDigPkg::phase_t       nextPhase;
    tmpDigPkg::windowCount_t timer;
    tmpDigPkg::stepCount_t   roundCount;
    logic                    ptatReady;
    logic                    bothCounted;

    function automatic tmpDigPkg::switchCtrl_t phaseSwitches(input tmpDigPkg::phase_t p);
        tmpDigPkg::switchCtrl_t sw;
        sw = '0;
        case (p)
            tmpDigPkg::PRECHARGE: begin
                sw.bgCtrl   = 1'b1;
                sw.ptatCtrl = 1'b1;
                sw.capRst   = 1'b1;
                sw.rDisconN = 1'b1;
            end
            tmpDigPkg::BANDGAP: begin
                sw.bg2Cmp   = 1'b1;
                sw.bgCtrl   = 1'b1;
                sw.capRst   = 1'b1;
                sw.rDisconN = 1'b1;
            end
            tmpDigPkg::PTAT: begin
                sw.bg2Cmp   = 1'b1;
                sw.ptatCtrl = 1'b1;
                sw.capRst   = 1'b1;
            end
            // caps released, oscillator drives the comparator
            tmpDigPkg::TEMPSENS: begin
                sw.ptatCtrl = 1'b1;
                sw.cap2Cmp  = 1'b1;
                sw.ref2Cmp  = 1'b1;
                sw.ptatOut  = 1'b1;
            end
            default: begin
                sw.capRst   = 1'b1;
                sw.rDisconN = 1'b1;
            end
        endcase
        return sw;
    endfunction

    assign ptatReady = (roundCount == tmpDigPkg::stepCount_t'(`TMPDIG_PTAT_MIN_ROUNDS));
    assign bothCounted = (count1 != '0) && (count2 != '0);

    always_comb begin
        nextPhase = phase;
        case (phase)
            tmpDigPkg::PRECHARGE: begin
                if (timer == tmpDigPkg::windowCount_t'(`TMPDIG_PRECHARGE_CYCLES)) begin
                    nextPhase = tmpDigPkg::BANDGAP;
                end
            end
            tmpDigPkg::BANDGAP: begin
                if (roundDone &&
                    roundCount == tmpDigPkg::stepCount_t'(`TMPDIG_BG_ROUNDS - 1)) begin
                    nextPhase = tmpDigPkg::PTAT;
                end
            end
            // leave only once the comparator has flipped against the last window
            tmpDigPkg::PTAT: begin
                if (ptatReady && cmpSync != polarity) begin
                    nextPhase = tmpDigPkg::TEMPSENS;
                end
            end
            tmpDigPkg::TEMPSENS: begin
                if (timer == tmpDigPkg::windowCount_t'(`TMPDIG_SAMPLE_WINDOW - 1)) begin
                    nextPhase = bothCounted ? tmpDigPkg::SLEEP : tmpDigPkg::PTAT;
                end
            end
            default: begin
                if (timer == tmpDigPkg::windowCount_t'(`TMPDIG_SLEEP_CYCLES - 1)) begin
                    nextPhase = tmpDigPkg::BANDGAP;
                end
            end
        endcase
    end

    always_ff @(posedge clk or posedge rstSync) begin
        if (rstSync) begin
            phase      <= tmpDigPkg::PRECHARGE;
            phaseStart <= 1'b0;
            switches   <= '0;
            pwrUp      <= 1'b0;
            preChrg    <= 1'b0;
            polarity   <= 1'b0;
            countClear <= 1'b0;
            timer      <= '0;
            roundCount <= '0;
        end else begin
            phase      <= nextPhase;
            phaseStart <= (nextPhase != phase);
            switches   <= phaseSwitches(nextPhase);
            pwrUp      <= (nextPhase != tmpDigPkg::SLEEP);
            preChrg    <= (nextPhase == tmpDigPkg::PRECHARGE);
            countClear <= (phase == tmpDigPkg::SLEEP) && (nextPhase != tmpDigPkg::SLEEP);
            if (nextPhase != phase) begin
                timer      <= '0;
                roundCount <= '0;
            end else begin
                timer <= timer + 1'b1;
                // PTAT rounds saturate at the minimum
                if (roundDone && !(phase == tmpDigPkg::PTAT && ptatReady)) begin
                    roundCount <= roundCount + 1'b1;
                end
            end
            if (phase == tmpDigPkg::PTAT && nextPhase == tmpDigPkg::TEMPSENS) begin
                polarity <= cmpSync;
            end
        end
    end

endmodule

//--- inputSync.sv
`timescale 1ns/1ps

module inputSync (
    input  logic clk,
    input  logic reset,
    input  logic cmp,
    output logic rstSync,
    output logic cmpSync
);

    logic [1:0] rstPipe;
    logic [1:0] cmpPipe;

    // asserts at once, releases on the second edge after reset falls
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rstPipe <= 2'b11;
        end else begin
            rstPipe <= {rstPipe[0], 1'b0};
        end
    end

    // comparator comes from the oscillator domain
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cmpPipe <= 2'b00;
        end else begin
            cmpPipe <= {cmpPipe[0], cmp};
        end
    end

    assign rstSync = rstPipe[1];
    assign cmpSync = cmpPipe[1];

endmodule

//--- tmpDigPkg.sv
`include "tmpDig_settings.svh"

package tmpDigPkg;

    typedef logic [`TMPDIG_COUNT_W-1:0] ccoCount_t;
    typedef logic [`TMPDIG_STEP_W-1:0] stepCount_t;
    typedef logic [`TMPDIG_WINDOW_W-1:0] windowCount_t;

    typedef enum logic [2:0] {
        SLEEP,
        PRECHARGE,
        BANDGAP,
        PTAT,
        TEMPSENS
    } phase_t;

    typedef enum logic [2:0] {
        DIODE,
        BIGDIODE,
        HCHARGE,
        LCHARGE,
        OUTPUT,
        BLANKDIODE,
        BLANKBIGDIODE
    } chopState_t;

    // bias and bridge switch pulses
    typedef struct packed {
        logic PI1;
        logic PI2;
        logic PII1;
        logic PII2;
        logic PA;
        logic PB;
        logic PC;
        logic PD;
        logic srcN;
        logic snk;
    } biasPulse_t;

    // analog path enables
    typedef struct packed {
        logic bg2Cmp;
        logic bgCtrl;
        logic ptatCtrl;
        logic cap2Cmp;
        logic ref2Cmp;
        logic capRst;
        logic ptatOut;
        logic rDisconN;
    } switchCtrl_t;

    typedef struct packed {
        logic ccoCap1;
        logic ccoCap2;
    } ccoCaps_t;

endpackage

//--- tmpDig_settings.svh
`ifndef TMPDIG_SETTINGS_SVH
`define TMPDIG_SETTINGS_SVH

// datapath widths
`define TMPDIG_COUNT_W 8
`define TMPDIG_STEP_W 8
`define TMPDIG_WINDOW_W 9

// precharge of the analog front end, in clk cycles
`define TMPDIG_PRECHARGE_CYCLES 16

// chopper step lengths
`define TMPDIG_DIODE_CYCLES 6
`define TMPDIG_BIGDIODE_TIMEOUT 11
`define TMPDIG_CHARGE_CYCLES 6
`define TMPDIG_BG_OUTPUT_CYCLES 5

// rounds per phase
`define TMPDIG_BG_ROUNDS 12
`define TMPDIG_PTAT_MIN_ROUNDS 7

// measurement and power-down timing
`define TMPDIG_SAMPLE_WINDOW 226
`define TMPDIG_SLEEP_CYCLES 32

`endif
